// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN       = 16;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;
    localparam int IMM_W      = 4;

    typedef enum logic [1:0] {
        CLASS_MEM  = 2'b00,
        CLASS_ALU  = 2'b01,
        CLASS_JUMP = 2'b10,
        CLASS_NOP  = 2'b11
    } instr_class_t;

    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, SHL, SHR, SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        J_NEVER, J_ALWAYS, J_ZERO, J_NONZERO, J_NEG
    } jump_cond_t;

    // Op field values inside the memory class
    localparam logic [2:0] MEM_LOAD  = 3'd0;
    localparam logic [2:0] MEM_STORE = 3'd1;

    typedef struct packed {
        instr_class_t          cls;
        logic                  form;
        logic [2:0]            op;
        logic [REG_ADDR_W-1:0] dst;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  unused;
    } instr_reg_t;

    typedef struct packed {
        instr_class_t          cls;
        logic                  form;
        logic [2:0]            op;
        logic [REG_ADDR_W-1:0] dst;
        logic [REG_ADDR_W-1:0] rs1;
        logic [IMM_W-1:0]      imm;
    } instr_imm_t;

    // Same word, two decodings selected by the form bit
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_word_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_REG_READ,
        ST_EXECUTE, ST_MEMORY, ST_MEM_WAIT, ST_WRITEBACK
    } stage_t;

endpackage

// ==== src/cpu_sequencer.sv ====
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    output stage_t stage,
    output logic   fetch_en,
    output logic   decode_en,
    output logic   read_en,
    output logic   exec_en,
    output logic   mem_en,
    output logic   wb_en
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= ST_IDLE;
        end else begin
            case (stage)
                ST_IDLE:      stage <= ST_FETCH;
                ST_FETCH:     stage <= ST_DECODE;
                ST_DECODE:    stage <= ST_REG_READ;
                ST_REG_READ:  stage <= ST_EXECUTE;
                ST_EXECUTE:   stage <= ST_MEMORY;
                ST_MEMORY:    stage <= ST_MEM_WAIT;
                ST_MEM_WAIT:  stage <= ST_WRITEBACK;
                ST_WRITEBACK: stage <= ST_IDLE;
                default:      stage <= ST_IDLE;
            endcase
        end
    end

    // One strobe per working stage, idle and memory wait have none
    assign fetch_en  = (stage == ST_FETCH);
    assign decode_en = (stage == ST_DECODE);
    assign read_en   = (stage == ST_REG_READ);
    assign exec_en   = (stage == ST_EXECUTE);
    assign mem_en    = (stage == ST_MEMORY);
    assign wb_en     = (stage == ST_WRITEBACK);

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_en,
    input  logic                  decode_en,
    input  logic [XLEN-1:0]       instr_in,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2_sel,
    output logic [REG_ADDR_W-1:0] dst,
    output logic [XLEN-1:0]       imm_se,
    output logic                  use_imm,
    output alu_op_t               alu_op,
    output jump_cond_t            jump_cond,
    output logic                  imm_jump,
    output logic                  mem_write,
    output logic                  mem_load,
    output logic                  reg_write
);

    instr_word_t  word_q;
    instr_class_t cls;
    logic [2:0]   op;
    logic         is_load;
    logic         is_store;
    logic         imm_form;
    alu_op_t      alu_op_d;
    jump_cond_t   jump_cond_d;

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            word_q <= instr_in;
        end
    end

    // Class and op sit at the same place in both views
    assign cls      = word_q.r.cls;
    assign op       = word_q.r.op;
    assign is_load  = (cls == CLASS_MEM) && (op == MEM_LOAD);
    assign is_store = (cls == CLASS_MEM) && (op == MEM_STORE);
    // Stores always take their offset from the immediate view
    assign imm_form = word_q.r.form || is_store;

    always_comb begin
        alu_op_d    = ADD;
        jump_cond_d = J_NEVER;
        if (cls == CLASS_ALU) begin
            alu_op_d = alu_op_t'(op);
        end
        // Unused condition codes never jump
        if ((cls == CLASS_JUMP) && (op <= J_NEG)) begin
            jump_cond_d = jump_cond_t'(op);
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            rs1     <= word_q.r.rs1;
            dst     <= word_q.r.dst;
            // Store data comes from the dst field through port B
            rs2_sel <= is_store ? word_q.r.dst : word_q.r.rs2;
            imm_se  <= imm_form ? {{(XLEN-IMM_W){word_q.i.imm[IMM_W-1]}}, word_q.i.imm} : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            use_imm   <= 1'b0;
            alu_op    <= ADD;
            jump_cond <= J_NEVER;
            imm_jump  <= 1'b0;
            mem_write <= 1'b0;
            mem_load  <= 1'b0;
            reg_write <= 1'b0;
        end else if (decode_en) begin
            use_imm   <= imm_form;
            alu_op    <= alu_op_d;
            jump_cond <= jump_cond_d;
            imm_jump  <= (cls == CLASS_JUMP) && word_q.i.form;
            mem_write <= is_store;
            mem_load  <= is_load;
            reg_write <= (cls == CLASS_ALU) || is_load;
        end
    end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read_en,
    input  logic                  wb_en,
    input  logic                  reg_write,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2_sel,
    input  logic [REG_ADDR_W-1:0] dst,
    input  logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       operand_a,
    output logic [XLEN-1:0]       operand_b
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && reg_write) begin
            regs[dst] <= wb_data;
        end
    end

    // Operands stay frozen from register read until the next instruction
    always_ff @(posedge clk) begin
        if (read_en) begin
            operand_a <= regs[rs1];
            operand_b <= regs[rs2_sel];
        end
    end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  logic [XLEN-1:0] imm_se,
    input  logic            use_imm,
    input  alu_op_t         alu_op,
    output logic [XLEN-1:0] alu_result
);

    logic [XLEN-1:0] in_b;
    logic [XLEN-1:0] result_d;

    assign in_b = use_imm ? imm_se : operand_b;

    always_comb begin
        case (alu_op)
            ADD:     result_d = operand_a + in_b;
            SUB:     result_d = operand_a - in_b;
            AND:     result_d = operand_a & in_b;
            OR:      result_d = operand_a | in_b;
            XOR:     result_d = operand_a ^ in_b;
            // Shift amount is the low nibble of B
            SHL:     result_d = operand_a << in_b[3:0];
            SHR:     result_d = operand_a >> in_b[3:0];
            SLT:     result_d = ($signed(operand_a) < $signed(in_b)) ? XLEN'(1) : '0;
            default: result_d = '0;
        endcase
    end

    // Result doubles as the memory address for loads and stores
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_result <= '0;
        end else if (exec_en) begin
            alu_result <= result_d;
        end
    end

endmodule

// ==== src/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,
    input  logic            wb_en,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  logic [XLEN-1:0] imm_se,
    input  logic            imm_jump,
    input  jump_cond_t      jump_cond,
    output logic [XLEN-1:0] pc
);

    logic            take_jump;
    logic            cond_met;
    logic [XLEN-1:0] target;

    always_comb begin
        case (jump_cond)
            J_ALWAYS:  cond_met = 1'b1;
            J_ZERO:    cond_met = (operand_a == '0);
            J_NONZERO: cond_met = (operand_a != '0);
            J_NEG:     cond_met = operand_a[XLEN-1];
            default:   cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            take_jump <= 1'b0;
            target    <= '0;
            pc        <= '0;
        end else begin
            if (exec_en) begin
                take_jump <= cond_met;
                // Immediate jumps are pc relative, register jumps absolute
                target    <= imm_jump ? (pc + imm_se) : operand_b;
            end
            if (wb_en) begin
                pc <= take_jump ? target : (pc + XLEN'(1));
            end
        end
    end

endmodule

// ==== src/memory_port.sv ====
`timescale 1ns/1ps

module memory_port import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_en,
    input  logic            mem_write,
    input  logic            mem_load,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] operand_b,
    input  logic [XLEN-1:0] pmem_data_in,
    output logic [XLEN-1:0] pmem_addr_out,
    output logic [XLEN-1:0] pmem_data_out,
    output logic            pmem_write,
    output logic [XLEN-1:0] wb_data
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pmem_addr_out <= '0;
            pmem_data_out <= '0;
            pmem_write    <= 1'b0;
        end else begin
            // Write strobe lasts exactly the memory wait cycle
            pmem_write <= mem_en && mem_write;
            if (mem_en) begin
                pmem_addr_out <= alu_result;
                pmem_data_out <= operand_b;
            end
        end
    end

    // RAM data is valid in writeback, one cycle after the address
    assign wb_data = mem_load ? pmem_data_in : alu_result;

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] instr_in,
    input  logic [XLEN-1:0] pmem_data_in,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pmem_data_out,
    output logic [XLEN-1:0] pmem_addr_out,
    output logic            pmem_write
);

    stage_t                stage;
    logic                  fetch_en;
    logic                  decode_en;
    logic                  read_en;
    logic                  exec_en;
    logic                  mem_en;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2_sel;
    logic [REG_ADDR_W-1:0] dst;
    logic [XLEN-1:0]       imm_se;
    logic                  use_imm;
    alu_op_t               alu_op;
    jump_cond_t            jump_cond;
    logic                  imm_jump;
    logic                  mem_write;
    logic                  mem_load;
    logic                  reg_write;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       wb_data;

    cpu_sequencer i_cpu_sequencer (
        .clk       (clk),
        .rst       (rst),
        .stage     (stage),
        .fetch_en  (fetch_en),
        .decode_en (decode_en),
        .read_en   (read_en),
        .exec_en   (exec_en),
        .mem_en    (mem_en),
        .wb_en     (wb_en)
    );

    instr_decoder i_instr_decoder (
        .clk       (clk),
        .rst       (rst),
        .fetch_en  (fetch_en),
        .decode_en (decode_en),
        .instr_in  (instr_in),
        .rs1       (rs1),
        .rs2_sel   (rs2_sel),
        .dst       (dst),
        .imm_se    (imm_se),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .jump_cond (jump_cond),
        .imm_jump  (imm_jump),
        .mem_write (mem_write),
        .mem_load  (mem_load),
        .reg_write (reg_write)
    );

    register_file i_register_file (
        .clk       (clk),
        .rst       (rst),
        .read_en   (read_en),
        .wb_en     (wb_en),
        .reg_write (reg_write),
        .rs1       (rs1),
        .rs2_sel   (rs2_sel),
        .dst       (dst),
        .wb_data   (wb_data),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    alu i_alu (
        .clk        (clk),
        .rst        (rst),
        .exec_en    (exec_en),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .imm_se     (imm_se),
        .use_imm    (use_imm),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    pc_unit i_pc_unit (
        .clk       (clk),
        .rst       (rst),
        .exec_en   (exec_en),
        .wb_en     (wb_en),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .imm_se    (imm_se),
        .imm_jump  (imm_jump),
        .jump_cond (jump_cond),
        .pc        (pc)
    );

    memory_port i_memory_port (
        .clk           (clk),
        .rst           (rst),
        .mem_en        (mem_en),
        .mem_write     (mem_write),
        .mem_load      (mem_load),
        .alu_result    (alu_result),
        .operand_b     (operand_b),
        .pmem_data_in  (pmem_data_in),
        .pmem_addr_out (pmem_addr_out),
        .pmem_data_out (pmem_data_out),
        .pmem_write    (pmem_write),
        .wb_data       (wb_data)
    );

endmodule

// ==== test/cpu_props.sv ====
`timescale 1ns/1ps

module cpu_props import cpu_pkg::*; (
    input logic            clk,
    input logic            rst,
    input stage_t          stage,
    input logic [XLEN-1:0] pc,
    input logic            pmem_write
);

    // Write strobe is a single cycle pulse
    a_write_single: assert property (
        @(posedge clk) disable iff (rst) pmem_write |=> !pmem_write
    ) else $error("pmem_write stayed high for two cycles in a row");

    a_write_stage: assert property (
        @(posedge clk) disable iff (rst) pmem_write |-> (stage == ST_MEM_WAIT)
    ) else $error("pmem_write high outside the memory wait stage");

    // pc moves only on the edge that closes writeback
    a_pc_update: assert property (
        @(posedge clk) disable iff (rst) !$stable(pc) |-> ($past(stage) == ST_WRITEBACK)
    ) else $error("pc changed on a cycle that does not follow writeback");

endmodule

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    // Worst case is 64 instructions of 8 cycles plus some margin
    localparam int TIMEOUT_CYCLES = 8 * 64 + 100;
    localparam int HALT_HOLD      = 16;
    localparam int NUM_STORES     = 4;

    logic            clk          = 1'b0;
    logic            rst          = 1'b1;
    logic [XLEN-1:0] instr_in     = '0;
    logic [XLEN-1:0] pmem_data_in = '0;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pmem_data_out;
    logic [XLEN-1:0] pmem_addr_out;
    logic            pmem_write;

    // Words 0-15 program, 16-23 RAM image, 24-31 store pairs, 32 final pc
    logic [XLEN-1:0] patterns [0:32];
    logic [XLEN-1:0] ram [0:7];

    logic [XLEN-1:0] prev_pc    = '0;
    logic [XLEN-1:0] prev_instr = '0;
    logic [5:0]      exp_idx    = '0;
    int              hold       = 0;
    int              cycles     = 0;
    int              store_idx  = 0;
    logic            done       = 1'b0;

    cpu_top i_cpu_top (
        .clk           (clk),
        .rst           (rst),
        .instr_in      (instr_in),
        .pmem_data_in  (pmem_data_in),
        .pc            (pc),
        .pmem_data_out (pmem_data_out),
        .pmem_addr_out (pmem_addr_out),
        .pmem_write    (pmem_write)
    );

    bind cpu_top cpu_props i_cpu_props (
        .clk        (clk),
        .rst        (rst),
        .stage      (stage),
        .pc         (pc),
        .pmem_write (pmem_write)
    );

    always #10 clk = ~clk;

    function automatic logic [XLEN-1:0] program_word(input logic [XLEN-1:0] addr);
        return patterns[{2'b00, addr[3:0]}];
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "stopped on a testbench error");
    endtask

    // ROM word follows pc one edge later, the idle stage hides that delay
    always @(posedge clk) begin
        instr_in <= program_word(pc);
    end

    // RAM with one cycle read latency, loaded from the pattern file in reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                ram[i] <= patterns[16 + i];
            end
        end else if (pmem_write) begin
            ram[pmem_addr_out[2:0]] <= pmem_data_out;
        end
        pmem_data_in <= ram[pmem_addr_out[2:0]];
    end

    // Outputs are sampled mid cycle
    always @(negedge clk) begin
        if (rst) begin
            check_value("pc", pc, '0);
            check_value("pmem_write", XLEN'(pmem_write), '0);
        end else if (!done) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("Timeout, the program did not finish its stores and halt");
            end else if (pc > 16'd15) begin
                stop_run("pc ran past the end of the program");
            end else begin
                if (pc != prev_pc) begin
                    check_value("pc hold cycles", XLEN'(hold), XLEN'(8));
                    prev_instr = program_word(prev_pc);
                    // Anything but a jump falls through to the next word
                    if (prev_instr[15:14] != 2'b10) begin
                        check_value("pc", pc, prev_pc + 16'd1);
                    end
                    prev_pc = pc;
                    hold    = 1;
                end else begin
                    hold++;
                end
                if (pmem_write) begin
                    if (store_idx >= NUM_STORES) begin
                        stop_run("A store was seen after the four expected stores");
                    end else begin
                        exp_idx = 6'(24 + 2 * store_idx);
                        check_value("pmem_addr_out", pmem_addr_out, patterns[exp_idx]);
                        check_value("pmem_data_out", pmem_data_out, patterns[exp_idx + 6'd1]);
                        store_idx++;
                    end
                end
                // Halt loop keeps pc parked on the final word
                if ((store_idx == NUM_STORES) && (pc == patterns[32]) && (hold >= HALT_HOLD)) begin
                    done = 1'b1;
                end
            end
        end
    end

    initial begin
        $readmemh("test/cpu_patterns.mem", patterns);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (done);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== test/cpu_patterns.mem ====
// Words 0-15 program, 16-23 initial RAM 0-7, 24-31 expected stores as address then data
// Word 32 final pc; one 16-bit hex word per line
6085 // addi r1, r0, 5
610D // addi r2, r0, -3
4594 // sub  r3, r1, r2
5234 // xor  r4, r3, r2
2601 // st   r4, 1(r0)
2282 // ld   r5, 2(r0)
42D2 // add  r5, r5, r1
269E // st   r5, -2(r1)
7713 // shli r6, r1, 3
A812 // jz   r1, +2 not taken
2704 // st   r6, 4(r0)
AC12 // jnz  r1, +2 taken
2487 // st   r1, 7(r0) skipped
5FA2 // slt  r7, r2, r1
2785 // st   r7, 5(r0)
A400 // jmp  +0 halt
0A01 // ram 0
0B02 // ram 1
1234 // ram 2
0C03 // ram 3
0D04 // ram 4
0E05 // ram 5
0F06 // ram 6
1007 // ram 7
0001 // store 1 address
FFF5 // store 1 data
0003 // store 2 address
1239 // store 2 data
0004 // store 3 address
0028 // store 3 data
0005 // store 4 address
0001 // store 4 data
000F // final pc

// ==== compile.f ====
src/cpu_pkg.sv
src/cpu_sequencer.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/pc_unit.sv
src/memory_port.sv
src/cpu_top.sv
test/cpu_props.sv
test/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build tb_cpu with Verilator, run it, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vtb_cpu > sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
